//--- tb.f
+incdir+tb
verilog/cpu_pkg.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/alu_pipeline_core.sv
tb/alu_pipeline_tb.sv

//--- tb/alu_pipeline_tests.svh
// no out_valid while idle and all registers read 0
task automatic reset_state();
  idle(4);
  for (int r = 0; r < reg_count; r++) begin
    send(op_out, r[2:0], 3'd0, 4'd0, 16'h0000, 16'h0000);
  end
  idle(3);
  check_flags(3'b000);
endtask

// distinct immediates in and read back in order
task automatic load_and_output();
  for (int r = 0; r < reg_count; r++) begin
    send(op_ldm, 3'd0, r[2:0], 4'd0, 16'ha5a0 + 16'(r * 16'h0111), 16'h0000);
  end
  for (int r = 0; r < reg_count; r++) begin
    send(op_out, r[2:0], 3'd0, 4'd0, 16'h0000, 16'h0000);
  end
  idle(3);
endtask

// dependent chain with gap bubbles between strobes
task automatic dependent_chain(input int gap);
  send(op_ldm, 3'd0, 3'd1, 4'd0, 16'h00ff, 16'h0000);
  idle(gap);
  send(op_ldm, 3'd0, 3'd2, 4'd0, 16'h0f01, 16'h0000);
  idle(gap);
  send(op_add, 3'd2, 3'd1, 4'd0, 16'h0000, 16'h0000);
  idle(gap);
  send(op_inc, 3'd0, 3'd1, 4'd0, 16'h0000, 16'h0000);
  idle(gap);
  send(op_sub, 3'd1, 3'd2, 4'd0, 16'h0000, 16'h0000);
  idle(gap);
  send(op_shl, 3'd0, 3'd2, 4'd3, 16'h0000, 16'h0000);
  idle(gap);
  // both operands name the register the shift just wrote
  send(op_add, 3'd2, 3'd2, 4'd0, 16'h0000, 16'h0000);
  send(op_out, 3'd1, 3'd0, 4'd0, 16'h0000, 16'h0000);
  send(op_out, 3'd2, 3'd0, 4'd0, 16'h0000, 16'h0000);
  idle(3);
endtask

task automatic forwarding();
  dependent_chain(0);
  dependent_chain(1);
endtask

// flags are zero, negative, carry
task automatic flag_updates();
  send(op_ldm, 3'd0, 3'd3, 4'd0, 16'hffff, 16'h0000);
  send(op_ldm, 3'd0, 3'd4, 4'd0, 16'h0002, 16'h0000);
  send(op_add, 3'd4, 3'd3, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b001);
  send(op_ldm, 3'd0, 3'd5, 4'd0, 16'h0007, 16'h0000);
  send(op_ldm, 3'd0, 3'd6, 4'd0, 16'h0007, 16'h0000);
  send(op_sub, 3'd6, 3'd5, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b100);
  // 1 - 5 borrows and goes negative
  send(op_ldm, 3'd0, 3'd5, 4'd0, 16'h0001, 16'h0000);
  send(op_ldm, 3'd0, 3'd6, 4'd0, 16'h0005, 16'h0000);
  send(op_sub, 3'd6, 3'd5, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b011);
  send(op_and, 3'd6, 3'd5, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b000);
  send(op_sub, 3'd6, 3'd6, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b100);
  // data moves keep the zero flag
  send(op_ldm, 3'd0, 3'd7, 4'd0, 16'h8000, 16'h0000);
  send(op_mov, 3'd7, 3'd0, 4'd0, 16'h0000, 16'h0000);
  send(op_out, 3'd0, 3'd0, 4'd0, 16'h0000, 16'h0000);
  check_flags(3'b100);
  idle(2);
endtask

// value taken at the strobe edge and kept through later port changes
task automatic input_port();
  send(op_in, 3'd0, 3'd2, 4'd0, 16'h0000, 16'h1234);
  in_port = 16'hbeef;
  idle(2);
  send(op_out, 3'd2, 3'd0, 4'd0, 16'h0000, 16'hbeef);
  idle(3);
endtask

task automatic random_stream();
  logic [31:0] x;
  logic [31:0] y;
  logic [4:0]  op;
  for (int n = 0; n < 200; n++) begin
    x = lcg_next();
    y = lcg_next();
    op = {1'b0, x[31:28]};
    // 15 swaps into the upper half, all undefined
    if (op == 5'd15) begin
      op = {1'b1, x[27:24]};
    end
    send(op, x[23:21], x[20:18], x[17:14], y[31:16], y[15:0]);
    if (x[13:12] == 2'b00) begin
      idle(1);
    end
    if (n % 5 == 4) begin
      send(op_out, x[10:8], 3'd0, 4'd0, 16'h0000, in_port);
    end
  end
  idle(3);
  check_flags(model_flags);
endtask

//--- tb/alu_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

module alu_pipeline_tb;

  import cpu_pkg::*;

  localparam int clk_period = 40;
  // rough cycle count of all tests, random stream dominates
  localparam int est_cycles = 400;
  localparam int watchdog_ns = (est_cycles + 200) * clk_period;

  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  logic [data_width-1:0] instr;
  logic [data_width-1:0] imm;
  logic [data_width-1:0] in_port;
  logic                  out_valid;
  logic [data_width-1:0] out_port;
  flags_t                flags;

  // reference model state
  logic [data_width-1:0] model_regs [reg_count];
  flags_t                model_flags;
  logic [data_width-1:0] exp_val [$];
  int                    exp_cycle [$];
  int                    cycle;
  int                    errors;
  logic [31:0]           lcg_state;

  alu_pipeline_core alu_pipeline_core_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .imm         (imm),
    .in_port     (in_port),
    .out_valid   (out_valid),
    .out_port    (out_port),
    .flags       (flags)
  );

  always #(clk_period / 2) clk = ~clk;

  // edge counter, out timing is checked against it
  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // one instruction through the model, in program order
  task automatic model_step(input logic [4:0] op, input logic [2:0] rs, rd,
                            input logic [3:0] shamt, input logic [15:0] value, in_value);
    logic [16:0] wide;
    logic [15:0] s;
    logic [15:0] d;
    logic [15:0] r;
    logic        upd;
    logic        c;
    s = model_regs[rs];
    d = model_regs[rd];
    r = d;
    upd = 1'b1;
    c = 1'b0;
    case (op)
      op_add: begin
        wide = {1'b0, d} + {1'b0, s};
        r = wide[15:0];
        c = wide[16];
      end
      op_sub: begin
        r = d - s;
        c = (d < s);
      end
      op_and: r = d & s;
      op_or:  r = d | s;
      op_not: r = ~d;
      op_inc: begin
        wide = {1'b0, d} + 17'd1;
        r = wide[15:0];
        c = wide[16];
      end
      op_shl: r = d << shamt;
      op_shr: r = d >> shamt;
      // data moves without touching flags
      op_mov: begin
        model_regs[rd] = s;
        upd = 1'b0;
      end
      op_ldm: begin
        model_regs[rd] = value;
        upd = 1'b0;
      end
      op_in: begin
        model_regs[rd] = in_value;
        upd = 1'b0;
      end
      // port shows rs two edges after the drive
      op_out: begin
        exp_val.push_back(s);
        exp_cycle.push_back(cycle + 2);
        upd = 1'b0;
      end
      default: upd = 1'b0;
    endcase
    if (upd) begin
      model_regs[rd] = r;
      model_flags.zero = (r == 16'h0000);
      model_flags.negative = r[15];
      model_flags.carry = c;
    end
  endtask

  // strobe one instruction, returns 2 ns after its sampling edge
  task automatic send(input logic [4:0] op, input logic [2:0] rs, rd,
                      input logic [3:0] shamt, input logic [15:0] value, in_value);
    instr = {op, rs, rd, shamt, 1'b0};
    imm = value;
    in_port = in_value;
    instr_valid = 1'b1;
    model_step(op, rs, rd, shamt, value, in_value);
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // flag register settles one edge after the op was sampled
  task automatic check_flags(input flags_t expected);
    idle(1);
    if (flags !== expected) begin
      errors++;
      $display("Error: flags expected %h got %h", expected, flags);
    end
  endtask

  // out port checker, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (out_valid) begin
        if (exp_val.size() == 0) begin
          errors++;
          $display("out_valid went high in cycle %0d with no out pending", cycle);
        end else begin
          if (out_port !== exp_val[0]) begin
            errors++;
            $display("Error: out_port expected %h got %h", exp_val[0], out_port);
          end
          if (cycle != exp_cycle[0]) begin
            errors++;
            $display("out_valid came in cycle %0d, expected cycle %0d", cycle, exp_cycle[0]);
          end
          void'(exp_val.pop_front());
          void'(exp_cycle.pop_front());
        end
      end else if (exp_val.size() != 0 && exp_cycle[0] < cycle) begin
        errors++;
        $display("out_valid missing in cycle %0d", exp_cycle[0]);
        void'(exp_val.pop_front());
        void'(exp_cycle.pop_front());
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("run stopped by the watchdog after %0d ns", watchdog_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    imm = '0;
    in_port = '0;
    cycle = 0;
    errors = 0;
    lcg_state = 32'd42;
    model_flags = '0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    // two cycles of reset
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    reset_state();
    load_and_output();
    forwarding();
    flag_updates();
    input_port();
    random_stream();
    idle(4);
    if (exp_val.size() != 0) begin
      errors++;
      $display("%0d expected outputs never appeared", exp_val.size());
    end
    $display("errors: %0d, cycles run: %0d", errors, cycle);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  `include "alu_pipeline_tests.svh"

endmodule

`default_nettype wire

//--- verilog/alu_pipeline_core.sv
`timescale 1ns/10ps
`default_nettype none

module alu_pipeline_core (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          instr_valid,
  input  logic [cpu_pkg::data_width-1:0] instr,
  input  logic [cpu_pkg::data_width-1:0] imm,
  input  logic [cpu_pkg::data_width-1:0] in_port,
  output logic                          out_valid,
  output logic [cpu_pkg::data_width-1:0] out_port,
  output cpu_pkg::flags_t               flags
);

  import cpu_pkg::*;

  decoded_t                  decoded;
  writeback_t                writeback;
  logic [reg_addr_width-1:0] read_addr_a;
  logic [reg_addr_width-1:0] read_addr_b;
  logic [data_width-1:0]     read_data_a;
  logic [data_width-1:0]     read_data_b;

  // stage 1
  decode_stage decode_stage_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .imm         (imm),
    .in_port     (in_port),
    .decoded     (decoded)
  );

  // written from the write-back register one edge after execute
  register_file register_file_i (
    .clk         (clk),
    .reset       (reset),
    .write_en    (writeback.valid && writeback.reg_write),
    .write_addr  (writeback.rd),
    .write_data  (writeback.value),
    .read_addr_a (read_addr_a),
    .read_addr_b (read_addr_b),
    .read_data_a (read_data_a),
    .read_data_b (read_data_b)
  );

  // stage 2
  execute_stage execute_stage_i (
    .clk         (clk),
    .reset       (reset),
    .decoded     (decoded),
    .read_data_a (read_data_a),
    .read_data_b (read_data_b),
    .read_addr_a (read_addr_a),
    .read_addr_b (read_addr_b),
    .writeback   (writeback),
    .flags       (flags)
  );

  // output port straight off the write-back register
  assign out_valid = writeback.valid && writeback.is_out;
  assign out_port  = writeback.value;

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_pkg::decoded_t                  decoded,
  input  logic [cpu_pkg::data_width-1:0]     read_data_a,
  input  logic [cpu_pkg::data_width-1:0]     read_data_b,
  output logic [cpu_pkg::reg_addr_width-1:0] read_addr_a,
  output logic [cpu_pkg::reg_addr_width-1:0] read_addr_b,
  output cpu_pkg::writeback_t                writeback,
  output cpu_pkg::flags_t                    flags
);

  import cpu_pkg::*;

  logic                  fwd_a;
  logic                  fwd_b;
  logic [data_width-1:0] src;
  logic [data_width-1:0] dst;
  logic [data_width-1:0] alu_result;
  flags_t                alu_flags;
  logic                  alu_flags_write;
  writeback_t            wb_next;

  // port a reads rs, port b reads rd
  assign read_addr_a = decoded.rs;
  assign read_addr_b = decoded.rd;

  // the write-back entry has not reached the file yet
  assign fwd_a = writeback.valid && writeback.reg_write && (writeback.rd == decoded.rs);
  assign fwd_b = writeback.valid && writeback.reg_write && (writeback.rd == decoded.rd);

  assign src = fwd_a ? writeback.value : read_data_a;
  assign dst = fwd_b ? writeback.value : read_data_b;

  alu alu_i (
    .opcode      (decoded.opcode),
    .src         (src),
    .dst         (dst),
    .shamt       (decoded.shamt),
    .flags_in    (flags),
    .result      (alu_result),
    .flags_out   (alu_flags),
    .flags_write (alu_flags_write)
  );

  // next write-back entry
  always_comb begin
    wb_next.valid     = decoded.valid;
    wb_next.reg_write = (decoded.opcode != op_nop) && (decoded.opcode != op_out);
    wb_next.is_out    = (decoded.opcode == op_out);
    wb_next.rd        = decoded.rd;
    case (decoded.opcode)
      op_ldm:  wb_next.value = decoded.imm;
      op_in:   wb_next.value = decoded.in_value;
      // out sends rs to the port
      op_out:  wb_next.value = src;
      default: wb_next.value = alu_result;
    endcase
  end

  // execute to write-back register
  always_ff @(posedge clk) begin
    writeback.rd    <= wb_next.rd;
    writeback.value <= wb_next.value;
    if (reset) begin
      writeback.valid     <= 1'b0;
      writeback.reg_write <= 1'b0;
      writeback.is_out    <= 1'b0;
    end else begin
      writeback.valid     <= wb_next.valid;
      writeback.reg_write <= wb_next.reg_write;
      writeback.is_out    <= wb_next.is_out;
    end
  end

  // flag register
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (decoded.valid && alu_flags_write) begin
      flags <= alu_flags;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  cpu_pkg::opcode_e                opcode,
  input  logic [cpu_pkg::data_width-1:0]  src,
  input  logic [cpu_pkg::data_width-1:0]  dst,
  input  logic [cpu_pkg::shamt_width-1:0] shamt,
  input  cpu_pkg::flags_t                 flags_in,
  output logic [cpu_pkg::data_width-1:0]  result,
  output cpu_pkg::flags_t                 flags_out,
  output logic                            flags_write
);

  import cpu_pkg::*;

  // one extra bit catches carry or borrow
  logic [data_width:0] sum;
  logic [data_width:0] diff;
  logic [data_width:0] incr;
  logic                carry_next;

  assign sum  = {1'b0, dst} + {1'b0, src};
  assign diff = {1'b0, dst} - {1'b0, src};
  assign incr = {1'b0, dst} + 1'b1;

  always_comb begin
    result      = dst;
    carry_next  = flags_in.carry;
    flags_write = 1'b1;
    case (opcode)
      op_add: begin
        result     = sum[data_width-1:0];
        carry_next = sum[data_width];
      end
      // top bit set when dst below src
      op_sub: begin
        result     = diff[data_width-1:0];
        carry_next = diff[data_width];
      end
      op_and: begin
        result     = dst & src;
        carry_next = 1'b0;
      end
      op_or: begin
        result     = dst | src;
        carry_next = 1'b0;
      end
      op_not: begin
        result     = ~dst;
        carry_next = 1'b0;
      end
      op_inc: begin
        result     = incr[data_width-1:0];
        carry_next = incr[data_width];
      end
      // logical shifts, zero fill
      op_shl: begin
        result     = dst << shamt;
        carry_next = 1'b0;
      end
      op_shr: begin
        result     = dst >> shamt;
        carry_next = 1'b0;
      end
      // mov copies src and keeps the flags
      op_mov: begin
        result      = src;
        flags_write = 1'b0;
      end
      default: begin
        flags_write = 1'b0;
      end
    endcase
  end

  // zero and negative track the result on flag writes only
  always_comb begin
    flags_out = flags_in;
    if (flags_write) begin
      flags_out.zero     = (result == '0);
      flags_out.negative = result[data_width-1];
      flags_out.carry    = carry_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              write_en,
  input  logic [cpu_pkg::reg_addr_width-1:0] write_addr,
  input  logic [cpu_pkg::data_width-1:0]     write_data,
  input  logic [cpu_pkg::reg_addr_width-1:0] read_addr_a,
  input  logic [cpu_pkg::reg_addr_width-1:0] read_addr_b,
  output logic [cpu_pkg::data_width-1:0]     read_data_a,
  output logic [cpu_pkg::data_width-1:0]     read_data_b
);

  import cpu_pkg::*;

  // general purpose registers r0 to r7
  logic [data_width-1:0] regs [reg_count];

  // single write port
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // two async read ports
  // stored value only, the execute stage forwards pending writes
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          instr_valid,
  input  logic [cpu_pkg::data_width-1:0] instr,
  input  logic [cpu_pkg::data_width-1:0] imm,
  input  logic [cpu_pkg::data_width-1:0] in_port,
  output cpu_pkg::decoded_t              decoded
);

  import cpu_pkg::*;

  // raw fields of the instruction word
  logic [opcode_width-1:0]   opcode_raw;
  logic [reg_addr_width-1:0] rs_field;
  logic [reg_addr_width-1:0] rd_field;
  logic [shamt_width-1:0]    shamt_field;
  opcode_e                   opcode_dec;

  assign opcode_raw  = instr[opcode_msb:opcode_lsb];
  assign rs_field    = instr[rs_msb:rs_lsb];
  assign rd_field    = instr[rd_msb:rd_lsb];
  assign shamt_field = instr[shamt_msb:shamt_lsb];

  // legal codes pass through
  // anything else becomes a nop
  always_comb begin
    case (opcode_raw)
      op_nop,
      op_mov,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_not,
      op_inc,
      op_shl,
      op_shr,
      op_ldm,
      op_in,
      op_out: opcode_dec = opcode_e'(opcode_raw);
      default: opcode_dec = op_nop;
    endcase
  end

  // decode register
  always_ff @(posedge clk) begin
    // payload only moves on a strobe
    if (instr_valid) begin
      decoded.opcode   <= opcode_dec;
      decoded.rs       <= rs_field;
      decoded.rd       <= rd_field;
      decoded.shamt    <= shamt_field;
      decoded.imm      <= imm;
      // input port sampled on the same edge as the instruction
      decoded.in_value <= in_port;
    end
    // a missing strobe leaves a bubble
    if (reset) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded.valid <= instr_valid;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath sizes
  localparam int data_width     = 16;
  localparam int reg_addr_width = 3;
  localparam int reg_count      = 8;
  localparam int shamt_width    = 4;
  localparam int opcode_width   = 5;

  // kept operations
  // codes not listed here decode as nop
  typedef enum logic [opcode_width-1:0] {
    op_nop = 5'd0,
    op_mov = 5'd1,
    op_add = 5'd2,
    op_sub = 5'd3,
    op_and = 5'd4,
    op_or  = 5'd5,
    op_not = 5'd6,
    op_inc = 5'd7,
    op_shl = 5'd8,
    op_shr = 5'd9,
    op_ldm = 5'd10,
    op_in  = 5'd11,
    op_out = 5'd12
  } opcode_e;

  // instruction word layout, bit 0 unused
  localparam int opcode_msb = 15;
  localparam int opcode_lsb = 11;
  localparam int rs_msb     = 10;
  localparam int rs_lsb     = 8;
  localparam int rd_msb     = 7;
  localparam int rd_lsb     = 5;
  localparam int shamt_msb  = 4;
  localparam int shamt_lsb  = 1;

  // condition flags
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } flags_t;

  // decode to execute payload
  typedef struct packed {
    logic                      valid;
    opcode_e                   opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rd;
    logic [shamt_width-1:0]    shamt;
    logic [data_width-1:0]     imm;
    logic [data_width-1:0]     in_value;
  } decoded_t;

  // execute to write-back payload
  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      is_out;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0]     value;
  } writeback_t;

endpackage

`default_nettype wire
